/* cdc_settings.svh */
`ifndef CDC_SETTINGS_SVH
`define CDC_SETTINGS_SVH

// log2 of the number of entries in each crossing FIFO
`define CDC_LOG_DEPTH 2
`define CDC_DEPTH (1 << `CDC_LOG_DEPTH)

// AXI-Lite address and data widths
`define CDC_ADDR_W 8
`define CDC_DATA_W 32

// Registers in the destination bank, one per 32-bit word
`define CDC_REG_COUNT 16

`endif

/* lite_cdc_pkg.sv */
`default_nettype none

`include "cdc_settings.svh"

package lite_cdc_pkg;

  typedef logic [`CDC_ADDR_W-1:0]   addr_t;
  typedef logic [`CDC_DATA_W-1:0]   data_t;
  typedef logic [`CDC_DATA_W/8-1:0] strb_t;

  // One extra bit over the index tells full from empty
  typedef logic [`CDC_LOG_DEPTH:0] ptr_t;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2
  } resp_e;

  typedef enum logic [1:0] {
    IDLE,
    B_RESP,
    R_RESP
  } bank_state_e;

  typedef struct packed {
    addr_t addr;
  } aw_chan_t;

  typedef struct packed {
    addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    data_t data;
    resp_e resp;
  } r_chan_t;

  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } lite_req_t;

  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } lite_resp_t;

  // Source to destination: request storage and write pointers, response read pointers
  typedef struct packed {
    aw_chan_t [`CDC_DEPTH-1:0] aw_data;
    ptr_t                      aw_wptr;
    w_chan_t  [`CDC_DEPTH-1:0] w_data;
    ptr_t                      w_wptr;
    ar_chan_t [`CDC_DEPTH-1:0] ar_data;
    ptr_t                      ar_wptr;
    ptr_t                      b_rptr;
    ptr_t                      r_rptr;
  } async_fwd_t;

  // Destination to source: request read pointers, response storage and write pointers
  typedef struct packed {
    ptr_t                      aw_rptr;
    ptr_t                      w_rptr;
    ptr_t                      ar_rptr;
    b_chan_t  [`CDC_DEPTH-1:0] b_data;
    ptr_t                      b_wptr;
    r_chan_t  [`CDC_DEPTH-1:0] r_data;
    ptr_t                      r_wptr;
  } async_bwd_t;

  function automatic ptr_t bin_to_gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray_to_bin(input ptr_t gray);
    ptr_t bin;
    bin[`CDC_LOG_DEPTH] = gray[`CDC_LOG_DEPTH];
    for (int i = `CDC_LOG_DEPTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

/* cdc_fifo_gray_src.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cdc_settings.svh"

module cdc_fifo_gray_src #(
  parameter type T = logic
) (
  input  logic               src_clk_i,
  input  logic               reset_i,
  input  T                   src_data_i,
  input  logic               src_valid_i,
  output logic               src_ready_o,
  output T [`CDC_DEPTH-1:0]  async_data_o,
  output lite_cdc_pkg::ptr_t async_wptr_o,
  input  lite_cdc_pkg::ptr_t async_rptr_i
);

  T [`CDC_DEPTH-1:0] mem_q;

  lite_cdc_pkg::ptr_t wptr_gray_q;
  lite_cdc_pkg::ptr_t wptr_bin;
  lite_cdc_pkg::ptr_t rptr_meta_q;
  lite_cdc_pkg::ptr_t rptr_sync_q;
  lite_cdc_pkg::ptr_t rptr_bin;
  logic               push;

  // Only the Gray pointer is kept, binary is derived for addressing
  assign wptr_bin = lite_cdc_pkg::gray_to_bin(wptr_gray_q);
  assign rptr_bin = lite_cdc_pkg::gray_to_bin(rptr_sync_q);

  // Full when the pointers differ by exactly the depth
  assign src_ready_o = (wptr_bin ^ rptr_bin) != {1'b1, {`CDC_LOG_DEPTH{1'b0}}};
  assign push        = src_valid_i && src_ready_o;

  assign async_data_o = mem_q;
  assign async_wptr_o = wptr_gray_q;

  always_ff @(posedge src_clk_i) begin
    if (push) begin
      mem_q[wptr_bin[`CDC_LOG_DEPTH-1:0]] <= src_data_i;
    end
  end

  always_ff @(posedge src_clk_i) begin
    if (reset_i) begin
      wptr_gray_q <= '0;
    end else if (push) begin
      wptr_gray_q <= lite_cdc_pkg::bin_to_gray(wptr_bin + lite_cdc_pkg::ptr_t'(1));
    end
  end

  // Two-flop synchronizer for the far-side read pointer
  always_ff @(posedge src_clk_i) begin
    if (reset_i) begin
      rptr_meta_q <= '0;
      rptr_sync_q <= '0;
    end else begin
      rptr_meta_q <= async_rptr_i;
      rptr_sync_q <= rptr_meta_q;
    end
  end

endmodule

`default_nettype wire

/* cdc_fifo_gray_dst.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cdc_settings.svh"

module cdc_fifo_gray_dst #(
  parameter type T = logic
) (
  input  logic               dst_clk_i,
  input  logic               reset_i,
  output T                   dst_data_o,
  output logic               dst_valid_o,
  input  logic               dst_ready_i,
  input  T [`CDC_DEPTH-1:0]  async_data_i,
  input  lite_cdc_pkg::ptr_t async_wptr_i,
  output lite_cdc_pkg::ptr_t async_rptr_o
);

  lite_cdc_pkg::ptr_t rptr_gray_q;
  lite_cdc_pkg::ptr_t rptr_bin;
  lite_cdc_pkg::ptr_t wptr_meta_q;
  lite_cdc_pkg::ptr_t wptr_sync_q;
  logic               pop;

  assign rptr_bin = lite_cdc_pkg::gray_to_bin(rptr_gray_q);

  // Empty when both Gray pointers agree
  assign dst_valid_o = rptr_gray_q != wptr_sync_q;

  // The entry is stable here, since the writer has moved its pointer past it
  assign dst_data_o = async_data_i[rptr_bin[`CDC_LOG_DEPTH-1:0]];

  assign pop          = dst_valid_o && dst_ready_i;
  assign async_rptr_o = rptr_gray_q;

  always_ff @(posedge dst_clk_i) begin
    if (reset_i) begin
      rptr_gray_q <= '0;
    end else if (pop) begin
      rptr_gray_q <= lite_cdc_pkg::bin_to_gray(rptr_bin + lite_cdc_pkg::ptr_t'(1));
    end
  end

  // Two-flop synchronizer for the far-side write pointer
  always_ff @(posedge dst_clk_i) begin
    if (reset_i) begin
      wptr_meta_q <= '0;
      wptr_sync_q <= '0;
    end else begin
      wptr_meta_q <= async_wptr_i;
      wptr_sync_q <= wptr_meta_q;
    end
  end

endmodule

`default_nettype wire

/* lite_cdc_src.sv */
`timescale 1ns/10ps
`default_nettype none

module lite_cdc_src (
  input  logic                     src_clk_i,
  input  logic                     reset_i,
  input  lite_cdc_pkg::lite_req_t  src_req_i,
  output lite_cdc_pkg::lite_resp_t src_resp_o,
  output lite_cdc_pkg::async_fwd_t async_fwd_o,
  input  lite_cdc_pkg::async_bwd_t async_bwd_i
);

  // Request channels leave this domain
  cdc_fifo_gray_src #(
    .T ( lite_cdc_pkg::aw_chan_t )
  ) i_cdc_fifo_gray_src_aw (
    .src_clk_i    ( src_clk_i            ),
    .reset_i      ( reset_i              ),
    .src_data_i   ( src_req_i.aw         ),
    .src_valid_i  ( src_req_i.aw_valid   ),
    .src_ready_o  ( src_resp_o.aw_ready  ),
    .async_data_o ( async_fwd_o.aw_data  ),
    .async_wptr_o ( async_fwd_o.aw_wptr  ),
    .async_rptr_i ( async_bwd_i.aw_rptr  )
  );

  cdc_fifo_gray_src #(
    .T ( lite_cdc_pkg::w_chan_t )
  ) i_cdc_fifo_gray_src_w (
    .src_clk_i    ( src_clk_i            ),
    .reset_i      ( reset_i              ),
    .src_data_i   ( src_req_i.w          ),
    .src_valid_i  ( src_req_i.w_valid    ),
    .src_ready_o  ( src_resp_o.w_ready   ),
    .async_data_o ( async_fwd_o.w_data   ),
    .async_wptr_o ( async_fwd_o.w_wptr   ),
    .async_rptr_i ( async_bwd_i.w_rptr   )
  );

  cdc_fifo_gray_src #(
    .T ( lite_cdc_pkg::ar_chan_t )
  ) i_cdc_fifo_gray_src_ar (
    .src_clk_i    ( src_clk_i            ),
    .reset_i      ( reset_i              ),
    .src_data_i   ( src_req_i.ar         ),
    .src_valid_i  ( src_req_i.ar_valid   ),
    .src_ready_o  ( src_resp_o.ar_ready  ),
    .async_data_o ( async_fwd_o.ar_data  ),
    .async_wptr_o ( async_fwd_o.ar_wptr  ),
    .async_rptr_i ( async_bwd_i.ar_rptr  )
  );

  // Response channels arrive from the far side
  cdc_fifo_gray_dst #(
    .T ( lite_cdc_pkg::b_chan_t )
  ) i_cdc_fifo_gray_dst_b (
    .dst_clk_i    ( src_clk_i            ),
    .reset_i      ( reset_i              ),
    .dst_data_o   ( src_resp_o.b         ),
    .dst_valid_o  ( src_resp_o.b_valid   ),
    .dst_ready_i  ( src_req_i.b_ready    ),
    .async_data_i ( async_bwd_i.b_data   ),
    .async_wptr_i ( async_bwd_i.b_wptr   ),
    .async_rptr_o ( async_fwd_o.b_rptr   )
  );

  cdc_fifo_gray_dst #(
    .T ( lite_cdc_pkg::r_chan_t )
  ) i_cdc_fifo_gray_dst_r (
    .dst_clk_i    ( src_clk_i            ),
    .reset_i      ( reset_i              ),
    .dst_data_o   ( src_resp_o.r         ),
    .dst_valid_o  ( src_resp_o.r_valid   ),
    .dst_ready_i  ( src_req_i.r_ready    ),
    .async_data_i ( async_bwd_i.r_data   ),
    .async_wptr_i ( async_bwd_i.r_wptr   ),
    .async_rptr_o ( async_fwd_o.r_rptr   )
  );

endmodule

`default_nettype wire

/* lite_cdc_dst.sv */
`timescale 1ns/10ps
`default_nettype none

module lite_cdc_dst (
  input  logic                     dst_clk_i,
  input  logic                     reset_i,
  output lite_cdc_pkg::lite_req_t  dst_req_o,
  input  lite_cdc_pkg::lite_resp_t dst_resp_i,
  input  lite_cdc_pkg::async_fwd_t async_fwd_i,
  output lite_cdc_pkg::async_bwd_t async_bwd_o
);

  // Requests come out of the crossing toward the bank
  cdc_fifo_gray_dst #(
    .T ( lite_cdc_pkg::aw_chan_t )
  ) i_cdc_fifo_gray_dst_aw (
    .dst_clk_i    ( dst_clk_i            ),
    .reset_i      ( reset_i              ),
    .dst_data_o   ( dst_req_o.aw         ),
    .dst_valid_o  ( dst_req_o.aw_valid   ),
    .dst_ready_i  ( dst_resp_i.aw_ready  ),
    .async_data_i ( async_fwd_i.aw_data  ),
    .async_wptr_i ( async_fwd_i.aw_wptr  ),
    .async_rptr_o ( async_bwd_o.aw_rptr  )
  );

  cdc_fifo_gray_dst #(
    .T ( lite_cdc_pkg::w_chan_t )
  ) i_cdc_fifo_gray_dst_w (
    .dst_clk_i    ( dst_clk_i            ),
    .reset_i      ( reset_i              ),
    .dst_data_o   ( dst_req_o.w          ),
    .dst_valid_o  ( dst_req_o.w_valid    ),
    .dst_ready_i  ( dst_resp_i.w_ready   ),
    .async_data_i ( async_fwd_i.w_data   ),
    .async_wptr_i ( async_fwd_i.w_wptr   ),
    .async_rptr_o ( async_bwd_o.w_rptr   )
  );

  cdc_fifo_gray_dst #(
    .T ( lite_cdc_pkg::ar_chan_t )
  ) i_cdc_fifo_gray_dst_ar (
    .dst_clk_i    ( dst_clk_i            ),
    .reset_i      ( reset_i              ),
    .dst_data_o   ( dst_req_o.ar         ),
    .dst_valid_o  ( dst_req_o.ar_valid   ),
    .dst_ready_i  ( dst_resp_i.ar_ready  ),
    .async_data_i ( async_fwd_i.ar_data  ),
    .async_wptr_i ( async_fwd_i.ar_wptr  ),
    .async_rptr_o ( async_bwd_o.ar_rptr  )
  );

  // Responses from the bank go back across
  cdc_fifo_gray_src #(
    .T ( lite_cdc_pkg::b_chan_t )
  ) i_cdc_fifo_gray_src_b (
    .src_clk_i    ( dst_clk_i            ),
    .reset_i      ( reset_i              ),
    .src_data_i   ( dst_resp_i.b         ),
    .src_valid_i  ( dst_resp_i.b_valid   ),
    .src_ready_o  ( dst_req_o.b_ready    ),
    .async_data_o ( async_bwd_o.b_data   ),
    .async_wptr_o ( async_bwd_o.b_wptr   ),
    .async_rptr_i ( async_fwd_i.b_rptr   )
  );

  cdc_fifo_gray_src #(
    .T ( lite_cdc_pkg::r_chan_t )
  ) i_cdc_fifo_gray_src_r (
    .src_clk_i    ( dst_clk_i            ),
    .reset_i      ( reset_i              ),
    .src_data_i   ( dst_resp_i.r         ),
    .src_valid_i  ( dst_resp_i.r_valid   ),
    .src_ready_o  ( dst_req_o.r_ready    ),
    .async_data_o ( async_bwd_o.r_data   ),
    .async_wptr_o ( async_bwd_o.r_wptr   ),
    .async_rptr_i ( async_fwd_i.r_rptr   )
  );

endmodule

`default_nettype wire

/* lite_reg_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cdc_settings.svh"

module lite_reg_bank (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  lite_cdc_pkg::lite_req_t  req_i,
  output lite_cdc_pkg::lite_resp_t resp_o
);

  localparam int unsigned IdxW = `CDC_ADDR_W - 2;

  lite_cdc_pkg::bank_state_e                      state_q;
  lite_cdc_pkg::bank_state_e                      state_d;
  lite_cdc_pkg::data_t [`CDC_REG_COUNT-1:0]       regs_q;
  lite_cdc_pkg::b_chan_t                          b_q;
  lite_cdc_pkg::r_chan_t                          r_q;

  logic [IdxW-1:0] aw_idx;
  logic [IdxW-1:0] ar_idx;
  logic            aw_hit;
  logic            ar_hit;
  logic            do_write;
  logic            do_read;

  // Word index from the byte address
  assign aw_idx = req_i.aw.addr[`CDC_ADDR_W-1:2];
  assign ar_idx = req_i.ar.addr[`CDC_ADDR_W-1:2];
  assign aw_hit = aw_idx < `CDC_REG_COUNT;
  assign ar_hit = ar_idx < `CDC_REG_COUNT;

  // A complete write wins over a read in the same cycle
  assign do_write = (state_q == lite_cdc_pkg::IDLE) && req_i.aw_valid && req_i.w_valid;
  assign do_read  = (state_q == lite_cdc_pkg::IDLE) && !(req_i.aw_valid && req_i.w_valid)
                    && req_i.ar_valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      lite_cdc_pkg::IDLE: begin
        if (do_write) begin
          state_d = lite_cdc_pkg::B_RESP;
        end else if (do_read) begin
          state_d = lite_cdc_pkg::R_RESP;
        end
      end
      lite_cdc_pkg::B_RESP: if (req_i.b_ready) state_d = lite_cdc_pkg::IDLE;
      lite_cdc_pkg::R_RESP: if (req_i.r_ready) state_d = lite_cdc_pkg::IDLE;
      default: state_d = lite_cdc_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= lite_cdc_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Byte-strobed write, out-of-range writes are dropped
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      regs_q <= '0;
    end else if (do_write && aw_hit) begin
      for (int b = 0; b < `CDC_DATA_W / 8; b++) begin
        if (req_i.w.strb[b]) begin
          regs_q[aw_idx][8*b +: 8] <= req_i.w.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      b_q.resp <= aw_hit ? lite_cdc_pkg::OKAY : lite_cdc_pkg::SLVERR;
    end
    if (do_read) begin
      r_q.data <= ar_hit ? regs_q[ar_idx] : '0;
      r_q.resp <= ar_hit ? lite_cdc_pkg::OKAY : lite_cdc_pkg::SLVERR;
    end
  end

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = do_write;
    resp_o.w_ready  = do_write;
    resp_o.ar_ready = do_read;
    resp_o.b        = b_q;
    resp_o.b_valid  = state_q == lite_cdc_pkg::B_RESP;
    resp_o.r        = r_q;
    resp_o.r_valid  = state_q == lite_cdc_pkg::R_RESP;
  end

endmodule

`default_nettype wire

/* lite_cdc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module lite_cdc_top (
  input  logic                     src_clk_i,
  input  logic                     dst_clk_i,
  input  logic                     reset_i,
  input  lite_cdc_pkg::lite_req_t  src_req_i,
  output lite_cdc_pkg::lite_resp_t src_resp_o
);

  // Only storage and Gray pointers cross between the halves
  lite_cdc_pkg::async_fwd_t async_fwd;
  lite_cdc_pkg::async_bwd_t async_bwd;

  // Bank-side bus in the destination clock
  lite_cdc_pkg::lite_req_t  dst_req;
  lite_cdc_pkg::lite_resp_t dst_resp;

  lite_cdc_src i_lite_cdc_src (
    .src_clk_i   ( src_clk_i  ),
    .reset_i     ( reset_i    ),
    .src_req_i   ( src_req_i  ),
    .src_resp_o  ( src_resp_o ),
    .async_fwd_o ( async_fwd  ),
    .async_bwd_i ( async_bwd  )
  );

  lite_cdc_dst i_lite_cdc_dst (
    .dst_clk_i   ( dst_clk_i  ),
    .reset_i     ( reset_i    ),
    .dst_req_o   ( dst_req    ),
    .dst_resp_i  ( dst_resp   ),
    .async_fwd_i ( async_fwd  ),
    .async_bwd_o ( async_bwd  )
  );

  lite_reg_bank i_lite_reg_bank (
    .clk_i   ( dst_clk_i ),
    .reset_i ( reset_i   ),
    .req_i   ( dst_req   ),
    .resp_o  ( dst_resp  )
  );

endmodule

`default_nettype wire

/* tb_lite_cdc_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cdc_settings.svh"

module tb_lite_cdc_top;

  localparam int Timeout      = 500;
  localparam int StallRelease = 40;

  logic src_clk_i = 1'b0;
  logic dst_clk_i = 1'b0;
  logic reset_i   = 1'b1;

  // Manager-side signals driven on the rising source clock
  lite_cdc_pkg::addr_t aw_addr  = '0;
  logic                aw_valid = 1'b0;
  lite_cdc_pkg::data_t w_data   = '0;
  lite_cdc_pkg::strb_t w_strb   = '0;
  logic                w_valid  = 1'b0;
  lite_cdc_pkg::addr_t ar_addr  = '0;
  logic                ar_valid = 1'b0;
  logic                b_ready  = 1'b0;
  logic                r_ready  = 1'b0;
  logic                hold_b   = 1'b0;

  lite_cdc_pkg::lite_req_t  src_req;
  lite_cdc_pkg::lite_resp_t src_resp;

  logic [31:0] gap_seed   = 32'd88548;
  logic [31:0] rdy_seed   = 32'd88548;
  bit          saw_stall  = 1'b0;
  int          pass_count = 0;
  int          fail_count = 0;

  lite_cdc_pkg::b_chan_t b_rcv[$];
  lite_cdc_pkg::r_chan_t r_rcv[$];
  string                 pend_name[$];
  lite_cdc_pkg::resp_e   pend_resp[$];
  bit                    pend_ok[$];

  // Reference copy of the register bank
  lite_cdc_pkg::data_t model [`CDC_REG_COUNT] = '{default: '0};

  always #10 src_clk_i = ~src_clk_i;
  always #17 dst_clk_i = ~dst_clk_i;

  always_comb begin
    src_req          = '0;
    src_req.aw.addr  = aw_addr;
    src_req.aw_valid = aw_valid;
    src_req.w.data   = w_data;
    src_req.w.strb   = w_strb;
    src_req.w_valid  = w_valid;
    src_req.b_ready  = b_ready;
    src_req.ar.addr  = ar_addr;
    src_req.ar_valid = ar_valid;
    src_req.r_ready  = r_ready;
  end

  lite_cdc_top lite_cdc_top_inst (
    .src_clk_i  ( src_clk_i ),
    .dst_clk_i  ( dst_clk_i ),
    .reset_i    ( reset_i   ),
    .src_req_i  ( src_req   ),
    .src_resp_o ( src_resp  )
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Random low periods on both response channels
  always @(posedge src_clk_i) begin
    rdy_seed = lcg_step(rdy_seed);
    b_ready <= !hold_b && (rdy_seed[17:16] != 2'b00);
    r_ready <= rdy_seed[20:19] != 2'b00;
  end

  // Nothing moves between the falling and the next rising edge
  always @(negedge src_clk_i) begin
    if (!reset_i && src_resp.b_valid && b_ready) begin
      b_rcv.push_back(src_resp.b);
    end
    if (!reset_i && src_resp.r_valid && r_ready) begin
      r_rcv.push_back(src_resp.r);
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic send_write(input lite_cdc_pkg::addr_t addr, input lite_cdc_pkg::data_t data,
                            input lite_cdc_pkg::strb_t strb);
    bit aw_done;
    bit w_done;
    bit aw_hs;
    bit w_hs;
    int cycles;
    int low_run;
    aw_done = 1'b0;
    w_done  = 1'b0;
    cycles  = 0;
    low_run = 0;
    @(posedge src_clk_i);
    aw_addr  <= addr;
    aw_valid <= 1'b1;
    w_data   <= data;
    w_strb   <= strb;
    w_valid  <= 1'b1;
    while (!(aw_done && w_done)) begin
      @(negedge src_clk_i);
      aw_hs = aw_valid && src_resp.aw_ready;
      w_hs  = w_valid && src_resp.w_ready;
      if (aw_valid && !src_resp.aw_ready && hold_b) begin
        saw_stall = 1'b1;
        low_run++;
      end else begin
        low_run = 0;
      end
      @(posedge src_clk_i);
      if (aw_hs) begin
        aw_valid <= 1'b0;
        aw_done = 1'b1;
      end
      if (w_hs) begin
        w_valid <= 1'b0;
        w_done = 1'b1;
      end
      // Release the held responses once the stall has lasted long enough
      if (low_run >= StallRelease) begin
        hold_b <= 1'b0;
      end
      cycles++;
      if (cycles > Timeout) begin
        abort_run("Timeout: write address or write data was never accepted");
      end
    end
  endtask

  task automatic send_read(input lite_cdc_pkg::addr_t addr);
    bit ar_done;
    int cycles;
    ar_done = 1'b0;
    cycles  = 0;
    @(posedge src_clk_i);
    ar_addr  <= addr;
    ar_valid <= 1'b1;
    while (!ar_done) begin
      @(negedge src_clk_i);
      ar_done = src_resp.ar_ready;
      @(posedge src_clk_i);
      if (ar_done) begin
        ar_valid <= 1'b0;
      end
      cycles++;
      if (cycles > Timeout) begin
        abort_run("Timeout: read address was never accepted");
      end
    end
  endtask

  task automatic wait_b_resp(input int count);
    int cycles;
    cycles = 0;
    while (b_rcv.size() < count) begin
      @(posedge src_clk_i);
      cycles++;
      if (cycles > Timeout) begin
        abort_run("Timeout: write response never arrived");
      end
    end
  endtask

  task automatic wait_r_resp();
    int cycles;
    cycles = 0;
    while (r_rcv.size() == 0) begin
      @(posedge src_clk_i);
      cycles++;
      if (cycles > Timeout) begin
        abort_run("Timeout: read response never arrived");
      end
    end
  endtask

  task automatic check_value(input string name, input string what, input logic [31:0] exp,
                             input logic [31:0] act, inout bit ok);
    assert (act === exp) else begin
      $display("** Error %s: %s expected %08h, actual %08h", name, what, exp, act);
      ok = 1'b0;
    end
  endtask

  task automatic report_test(input string name, input bit ok);
    if (ok) begin
      pass_count++;
      $display("Test %s passed", name);
    end else begin
      fail_count++;
      $display("Test %s failed", name);
    end
  endtask

  initial begin
    int                       fd;
    int                       fields;
    string                    line;
    string                    name;
    string                    op;
    logic [31:0]              t_addr;
    logic [31:0]              t_data;
    logic [31:0]              t_strb;
    logic [31:0]              t_resp;
    logic [31:0]              t_rdata;
    logic [`CDC_ADDR_W-3:0]   idx;
    bit                       hit;
    bit                       ok;
    bit                       item_ok;
    lite_cdc_pkg::resp_e      exp_resp;
    lite_cdc_pkg::data_t      exp_data;
    lite_cdc_pkg::b_chan_t    got_b;
    lite_cdc_pkg::r_chan_t    got_r;

    repeat (4) @(posedge dst_clk_i);
    @(posedge src_clk_i);
    reset_i <= 1'b0;

    fd = $fopen("lite_cdc_trace.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open lite_cdc_trace.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        fields = $sscanf(line, "%s %s %h %h %h %h %h", name, op, t_addr, t_data, t_strb,
                         t_resp, t_rdata);
        if (fields != 7) begin
          abort_run($sformatf("Malformed trace line: %s", line));
        end
        ok       = 1'b1;
        idx      = t_addr[`CDC_ADDR_W-1:2];
        hit      = idx < `CDC_REG_COUNT;
        exp_resp = hit ? lite_cdc_pkg::OKAY : lite_cdc_pkg::SLVERR;
        exp_data = hit ? model[idx] : '0;

        if (op != "D") begin
          assert (t_resp[1:0] == exp_resp && (op != "R" || t_rdata == exp_data)) else begin
            $display("Trace line %s does not agree with the bank model", name);
            ok = 1'b0;
          end
          gap_seed = lcg_step(gap_seed);
          repeat (gap_seed[18:17]) @(posedge src_clk_i);
        end

        case (op)
          "W", "P": begin
            // Only strobed bytes of an in-range word change
            for (int b = 0; b < `CDC_DATA_W / 8; b++) begin
              if (hit && t_strb[b]) begin
                model[idx][8*b +: 8] = t_data[8*b +: 8];
              end
            end
            if (op == "P" && pend_name.size() == 0) begin
              hold_b <= 1'b1;
              saw_stall = 1'b0;
            end
            send_write(t_addr[`CDC_ADDR_W-1:0], t_data, t_strb[`CDC_DATA_W/8-1:0]);
            if (op == "P") begin
              pend_name.push_back(name);
              pend_resp.push_back(exp_resp);
              pend_ok.push_back(ok);
            end else begin
              wait_b_resp(1);
              got_b = b_rcv.pop_front();
              check_value(name, "resp", 32'(exp_resp), 32'(got_b.resp), ok);
            end
          end
          "R": begin
            send_read(t_addr[`CDC_ADDR_W-1:0]);
            wait_r_resp();
            got_r = r_rcv.pop_front();
            check_value(name, "resp", 32'(exp_resp), 32'(got_r.resp), ok);
            check_value(name, "data", exp_data, got_r.data, ok);
          end
          "D": begin
            assert (saw_stall) else begin
              $display("aw_ready never dropped while write responses were held back");
              ok = 1'b0;
            end
            hold_b <= 1'b0;
            wait_b_resp(pend_resp.size());
            // Held responses come back in issue order
            while (pend_resp.size() > 0) begin
              item_ok = pend_ok.pop_front();
              got_b   = b_rcv.pop_front();
              check_value(pend_name[0], "resp", 32'(pend_resp.pop_front()), 32'(got_b.resp),
                          item_ok);
              report_test(pend_name.pop_front(), item_ok);
            end
          end
          default: begin
            abort_run($sformatf("Unknown operation %s in trace line %s", op, name));
          end
        endcase

        if (op != "P") begin
          report_test(name, ok);
        end
      end
      $fclose(fd);

      // Every response on the bus must belong to a request of the trace
      assert (b_rcv.size() == 0 && r_rcv.size() == 0) else begin
        $display("Responses arrived that no request asked for");
        fail_count++;
      end

      $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* lite_cdc_trace.txt */
# name op addr data strb resp rdata, all numbers in hex
# op W write, R read, P write with responses held back, D release and check held responses
full_wr    W 04 a5a51234 f 0 00000000
full_rd    R 04 00000000 0 0 a5a51234
part_wr    W 04 deadbeef 5 0 00000000
part_rd    R 04 00000000 0 0 a5ad12ef
reg0_wr    W 00 11223344 f 0 00000000
oor_wr     W 40 ffffffff f 2 00000000
oor_rd     R fc 00000000 0 2 00000000
reg0_rd    R 00 00000000 0 0 11223344
bp_wr0     P 20 10000001 f 0 00000000
bp_wr1     P 24 10000002 f 0 00000000
bp_wr2     P 28 10000003 f 0 00000000
bp_wr3     P 2c 10000004 f 0 00000000
bp_wr4     P 30 10000005 f 0 00000000
bp_wr5     P 34 10000006 f 0 00000000
bp_wr6     P 38 10000007 f 0 00000000
bp_wr7     P 3c 10000008 f 0 00000000
bp_wr8     P 20 10000009 f 0 00000000
bp_wr9     P 24 1000000a f 0 00000000
bp_drain   D 00 00000000 0 0 00000000
bp_rd8     R 20 00000000 0 0 10000009
bp_rd9     R 24 00000000 0 0 1000000a
bp_rd15    R 3c 00000000 0 0 10000008
mix_wr4    W 10 cafef00d 3 0 00000000
mix_rd4    R 10 00000000 0 0 0000f00d
mix_oor    R 44 00000000 0 2 00000000
mix_wr15   W 3c 00000000 c 0 00000000
mix_rd15   R 3c 00000000 0 0 00000008

/* lite_cdc_top.f */
+incdir+.
lite_cdc_pkg.sv
cdc_fifo_gray_src.sv
cdc_fifo_gray_dst.sv
lite_cdc_src.sv
lite_cdc_dst.sv
lite_reg_bank.sv
lite_cdc_top.sv
tb_lite_cdc_top.sv
